/* files.f */
+incdir+design
design/soc_pkg.sv
design/reset_gen.sv
design/wb_decoder.sv
design/wb_bram.sv
design/csr_bridge.sv
design/sysctl.sv
design/sys_timer.sv
design/soc_top.sv
sim/tb_soc.sv

/* Bender.yml */
package:
  name: soc_slice

export_include_dirs:
  - design

sources:
  - files:
      - design/soc_pkg.sv
      - design/reset_gen.sv
      - design/wb_decoder.sv
      - design/wb_bram.sv
      - design/csr_bridge.sv
      - design/sysctl.sv
      - design/sys_timer.sv
      - design/soc_top.sv
  - target: test
    files:
      - sim/tb_soc.sv

/* sim/tb_soc.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc
	import soc_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DLY = 2;
	// longest run in cycles, about five times the expected length
	localparam int TEST_CYCLES_MAX = 10000;
	localparam logic [31:0] CSR_BASE = 32'h6000_1000;
	localparam logic [31:0] SHADOW = 32'h8000_0000;
	localparam int RAM_WORDS = 16;
	// cycles from first sampled strobe edge to ack, per region
	localparam int LAT_RAM = 1;
	localparam int LAT_CSR = 3;
	localparam int LAT_NONE = 1;

	logic sys_clk;
	logic trigger_reset_i;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [`GPIO_IN_W-1:0] gpio;
	logic [`GPIO_OUT_W-1:0] leds;
	irq_t irq;
	logic sys_rst;

	logic [31:0] lfsr_q;
	int unsigned cycle_cnt = 0;
	int unsigned timer_pulses [$];
	int gpio_irq_cnt = 0;
	int rst_run = 0;
	logic soft_armed = 1'b0;
	logic soft_checked = 1'b0;
	logic [31:0] ram_model [2**`BRAM_AW];
	logic [`BRAM_AW-1:0] ram_idx [RAM_WORDS];

	soc_top dut_i (
		.sys_clk(sys_clk),
		.trigger_reset_i(trigger_reset_i),
		.wb_i(wb_req),
		.gpio_i(gpio),
		.wb_o(wb_rsp),
		.leds_o(leds),
		.irq_o(irq),
		.sys_rst_o(sys_rst)
	);

	// ------------------------------------------------------------
	// error exits
	// ------------------------------------------------------------
	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_abort(input string msg);
		$display("error: %s", msg);
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	// ------------------------------------------------------------
	// random data
	// ------------------------------------------------------------
	// right-shift galois form, taps 32,30,26,25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'ha300_0000;
		return n;
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	function automatic logic [31:0] ram_addr(input logic [`BRAM_AW-1:0] idx);
		return 32'(idx) << 2;
	endfunction

	function automatic logic [31:0] csr_reg(input int idx);
		return CSR_BASE + 32'(idx) * 4;
	endfunction

	// ------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------
	// lat counts rising edges from the strobe until ack is seen
	task automatic wb_cycle(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, input logic we,
			output logic [31:0] rdat, output int lat);
		lat = 0;
		while (sys_rst !== 1'b0)
			@(negedge sys_clk);
		@(posedge sys_clk);
		#DRIVE_DLY;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.sel = sel;
		wb_req.we = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		forever begin
			@(posedge sys_clk);
			lat++;
			// mid-cycle sample, outputs settled
			@(negedge sys_clk);
			if (wb_rsp.ack === 1'b1)
				break;
			if (lat >= 16)
				report_abort($sformatf("no ack for access to %h", adr));
		end
		rdat = wb_rsp.dat;
		// stb drops in the cycle after ack
		@(posedge sys_clk);
		#DRIVE_DLY;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, input int exp_lat);
		logic [31:0] rdat;
		int lat;
		wb_cycle(adr, dat, sel, 1'b1, rdat, lat);
		assert (lat == exp_lat)
			else report_mismatch($sformatf("write %h acked after %0d cycles, expected %0d",
				adr, lat, exp_lat));
	endtask

	task automatic expect_read(input logic [31:0] adr, input logic [31:0] exp,
			input int exp_lat);
		logic [31:0] rdat;
		int lat;
		wb_cycle(adr, 32'd0, 4'hf, 1'b0, rdat, lat);
		assert (lat == exp_lat)
			else report_mismatch($sformatf("read %h acked after %0d cycles, expected %0d",
				adr, lat, exp_lat));
		assert (rdat === exp)
			else report_mismatch($sformatf("read %h returned %h, expected %h", adr, rdat, exp));
	endtask

	// ------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------
	always @(posedge sys_clk)
		cycle_cnt++;

	// pulses logged mid-cycle, tests read them at the rising edge
	always @(negedge sys_clk) begin
		if (irq.timer === 1'b1)
			timer_pulses.push_back(cycle_cnt);
		if (irq.gpio === 1'b1)
			gpio_irq_cnt++;
	end

	// length of each reset run, checked once soft reset is armed
	always @(negedge sys_clk) begin
		if (sys_rst === 1'b1) begin
			rst_run++;
		end else begin
			if (soft_armed && rst_run != 0) begin
				assert (rst_run == `RST_HOLD_CYCLES)
					else report_mismatch($sformatf("soft reset held %0d cycles", rst_run));
				soft_checked = 1'b1;
			end
			rst_run = 0;
		end
	end

	a_ack_pulse: assert property (
		@(posedge sys_clk) disable iff (sys_rst !== 1'b0)
		wb_rsp.ack |=> !wb_rsp.ack
	) else report_mismatch("bus ack lasted two cycles");

	// everything quiet one cycle into reset
	a_reset_quiet: assert property (
		@(posedge sys_clk) sys_rst |=> (leds == '0 && irq == '0 && !wb_rsp.ack)
	) else report_mismatch("leds, irq or ack active during reset");

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic check_ram();
		for (int k = 0; k < RAM_WORDS; k++) begin
			expect_read(ram_addr(ram_idx[k]), ram_model[ram_idx[k]], LAT_RAM);
			// shadow window, bit 31 set
			expect_read(SHADOW | ram_addr(ram_idx[k]), ram_model[ram_idx[k]], LAT_RAM);
		end
	endtask

	task automatic test_ram();
		logic [31:0] v;
		logic [31:0] s;
		// full words first so every byte of the model is known
		for (int k = 0; k < RAM_WORDS; k++) begin
			rand_bits(`BRAM_AW, v);
			ram_idx[k] = v[`BRAM_AW-1:0];
			rand_bits(32, v);
			ram_model[ram_idx[k]] = v;
			bus_write(ram_addr(ram_idx[k]), v, 4'hf, LAT_RAM);
		end
		// then byte lanes
		for (int k = 0; k < RAM_WORDS; k++) begin
			rand_bits(4, s);
			rand_bits(32, v);
			for (int b = 0; b < 4; b++) begin
				if (s[b])
					ram_model[ram_idx[k]][b*8 +: 8] = v[b*8 +: 8];
			end
			bus_write(ram_addr(ram_idx[k]), v, s[3:0], LAT_RAM);
		end
		check_ram();
	endtask

	task automatic test_bus();
		expect_read(csr_reg(`REG_SYSTEM_ID), `SYSTEM_ID, LAT_CSR);
		expect_read(SHADOW | csr_reg(`REG_SYSTEM_ID), `SYSTEM_ID, LAT_CSR);
		// banks 0 and 2 are empty
		expect_read(32'h6000_0014, 32'd0, LAT_CSR);
		expect_read(32'h6000_2014, 32'd0, LAT_CSR);
		// unmapped regions
		expect_read(32'h3000_0010, 32'd0, LAT_NONE);
		bus_write(32'hb000_0000, 32'hffff_ffff, 4'hf, LAT_NONE);
	endtask

	task automatic test_gpio();
		logic [31:0] v;
		rand_bits(32, v);
		bus_write(csr_reg(`REG_GPIO_OUT), v, 4'hf, LAT_CSR);
		assert (leds == v[`GPIO_OUT_W-1:0])
			else report_mismatch($sformatf("leds %h, expected %h", leds, v[3:0]));
		rand_bits(32, v);
		v[0] = 1'b1;
		gpio_irq_cnt = 0;
		@(posedge sys_clk);
		#DRIVE_DLY;
		gpio = v;
		repeat (3) @(posedge sys_clk);
		expect_read(csr_reg(`REG_GPIO_IN), v, LAT_CSR);
		repeat (4) @(posedge sys_clk);
		assert (gpio_irq_cnt == 1)
			else report_mismatch($sformatf("%0d gpio irq pulses, expected 1", gpio_irq_cnt));
	endtask

	task automatic wait_pulses(input int n);
		int waited;
		waited = 0;
		while (timer_pulses.size() < n) begin
			@(posedge sys_clk);
			waited++;
			if (waited > 400)
				report_abort("timer irq never pulsed");
		end
	endtask

	task automatic test_timer();
		logic [31:0] c;
		logic [31:0] v;
		// autorestart, period compare+1
		rand_bits(4, c);
		c = c + 2;
		bus_write(csr_reg(`REG_TIMER_COMPARE), c, 4'hf, LAT_CSR);
		timer_pulses.delete();
		bus_write(csr_reg(`REG_TIMER_CTRL), 32'h3, 4'hf, LAT_CSR);
		wait_pulses(4);
		for (int i = 1; i < 4; i++) begin
			assert (timer_pulses[i] - timer_pulses[i-1] == c + 1)
				else report_mismatch($sformatf("timer pulses %0d cycles apart, expected %0d",
					timer_pulses[i] - timer_pulses[i-1], c + 1));
		end
		bus_write(csr_reg(`REG_TIMER_CTRL), 32'h0, 4'hf, LAT_CSR);
		// one-shot from zero
		bus_write(csr_reg(`REG_TIMER_COUNTER), 32'h0, 4'hf, LAT_CSR);
		rand_bits(5, c);
		c = c + 3;
		bus_write(csr_reg(`REG_TIMER_COMPARE), c, 4'hf, LAT_CSR);
		timer_pulses.delete();
		bus_write(csr_reg(`REG_TIMER_CTRL), 32'h1, 4'hf, LAT_CSR);
		wait_pulses(1);
		expect_read(csr_reg(`REG_TIMER_CTRL), 32'h0, LAT_CSR);
		// counter preload, timer stopped
		rand_bits(32, v);
		bus_write(csr_reg(`REG_TIMER_COUNTER), v, 4'hf, LAT_CSR);
		expect_read(csr_reg(`REG_TIMER_COUNTER), v, LAT_CSR);
	endtask

	task automatic test_soft_reset();
		int waited;
		waited = 0;
		bus_write(csr_reg(`REG_GPIO_OUT), 32'ha, 4'hf, LAT_CSR);
		soft_armed = 1'b1;
		bus_write(csr_reg(`REG_RESET), 32'h1, 4'hf, LAT_CSR);
		while (!soft_checked) begin
			@(posedge sys_clk);
			waited++;
			if (waited > 4 * `RST_HOLD_CYCLES)
				report_abort("soft reset did not run and release");
		end
		assert (leds == '0)
			else report_mismatch($sformatf("leds %h after soft reset", leds));
		// ram is not cleared by reset
		check_ram();
	endtask

	// ------------------------------------------------------------
	// clock, watchdog, main sequence
	// ------------------------------------------------------------
	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(TEST_CYCLES_MAX * CLK_PERIOD);
		$display("error: watchdog expired after %0d cycles", TEST_CYCLES_MAX);
		$display("sim failed");
		$fatal(1, "watchdog");
	end

	initial begin
		trigger_reset_i = 1'b1;
		wb_req = '0;
		gpio = '0;
		lfsr_q = 32'hf51e_8de0;
		repeat (16) @(posedge sys_clk);
		#DRIVE_DLY;
		trigger_reset_i = 1'b0;
		test_ram();
		test_bus();
		test_gpio();
		test_timer();
		test_soft_reset();
		repeat (4) @(posedge sys_clk);
		$display("sim passed");
		$finish;
	end

endmodule

/* design/soc_top.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic trigger_reset_i,
	input wb_req_t wb_i,
	input logic [`GPIO_IN_W-1:0] gpio_i,
	output wb_rsp_t wb_o,
	output logic [`GPIO_OUT_W-1:0] leds_o,
	output irq_t irq_o,
	output logic sys_rst_o
);

	wb_req_t ram_req;
	wb_req_t brg_req;
	wb_rsp_t ram_rsp;
	wb_rsp_t brg_rsp;
	csr_req_t csr_req;
	logic [`SOC_DW-1:0] csr_dr;
	timer_ctrl_t timer_ctrl;
	logic [31:0] timer_count;
	logic timer_expire;
	logic soft_reset;

	// ------------------------------------------------------------
	// reset
	// ------------------------------------------------------------
	reset_gen u_reset_gen (
		.sys_clk(sys_clk),
		.trigger_reset_i(trigger_reset_i),
		.soft_reset_i(soft_reset),
		.sys_rst_o(sys_rst_o)
	);

	// ------------------------------------------------------------
	// wishbone
	// ------------------------------------------------------------
	// ram at 0x0000_0000, csr at 0x6000_0000, both shadowed at +0x8000_0000
	wb_decoder u_decoder (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.m_req_i(wb_i),
		.m_rsp_o(wb_o),
		.ram_req_o(ram_req),
		.csr_req_o(brg_req),
		.ram_rsp_i(ram_rsp),
		.csr_rsp_i(brg_rsp)
	);

	wb_bram u_bram (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.wb_req_i(ram_req),
		.wb_rsp_o(ram_rsp)
	);

	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.wb_req_i(brg_req),
		.wb_rsp_o(brg_rsp),
		.csr_o(csr_req),
		.csr_dr_i(csr_dr)
	);

	// ------------------------------------------------------------
	// system controller, csr bank 1
	// ------------------------------------------------------------
	sysctl u_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.csr_i(csr_req),
		.csr_dr_o(csr_dr),
		.gpio_i(gpio_i),
		.leds_o(leds_o),
		.timer_o(timer_ctrl),
		.timer_count_i(timer_count),
		.timer_expire_i(timer_expire),
		.irq_o(irq_o),
		.soft_reset_o(soft_reset)
	);

	sys_timer u_timer (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.ctrl_i(timer_ctrl),
		.count_o(timer_count),
		.expire_o(timer_expire)
	);

endmodule

/* design/sys_timer.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module sys_timer
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input timer_ctrl_t ctrl_i,
	output logic [31:0] count_o,
	output logic expire_o
);

	logic [31:0] count_q;
	logic match;

	// ------------------------------------------------------------
	// counter
	// ------------------------------------------------------------
	// 0..compare, so one period is compare+1 cycles
	assign match = ctrl_i.en & (count_q == ctrl_i.compare);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			count_q <= '0;
		end else if (ctrl_i.load) begin
			// software preload wins
			count_q <= ctrl_i.load_val;
		end else if (match) begin
			count_q <= '0;
		end else if (ctrl_i.en) begin
			count_q <= count_q + 32'd1;
		end
	end

	// expire lines up with the wrap edge
	// sysctl drops en on the same edge in one-shot mode
	assign expire_o = match & ~ctrl_i.load;
	assign count_o = count_q;

endmodule

/* design/sysctl.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module sysctl
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input csr_req_t csr_i,
	output logic [`SOC_DW-1:0] csr_dr_o,
	input logic [`GPIO_IN_W-1:0] gpio_i,
	output logic [`GPIO_OUT_W-1:0] leds_o,
	output timer_ctrl_t timer_o,
	input logic [31:0] timer_count_i,
	input logic timer_expire_i,
	output irq_t irq_o,
	output logic soft_reset_o
);

	logic sel;
	logic [`CSR_AW-5:0] reg_idx;
	logic [`GPIO_IN_W-1:0] gpio_s1;
	logic [`GPIO_IN_W-1:0] gpio_s2;
	logic [`GPIO_IN_W-1:0] gpio_prev;

	// bank in the top 4 address bits
	assign sel = (csr_i.a[`CSR_AW-1:`CSR_AW-4] == `CSR_BANK_SYSCTL);
	assign reg_idx = csr_i.a[`CSR_AW-5:0];

	// ------------------------------------------------------------
	// gpio inputs
	// ------------------------------------------------------------
	// two-flop synchronizer, plus one for edge detect
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_s1 <= '0;
			gpio_s2 <= '0;
			gpio_prev <= '0;
		end else begin
			gpio_s1 <= gpio_i;
			gpio_s2 <= gpio_s1;
			gpio_prev <= gpio_s2;
		end
	end

	// any bit change pulses gpio irq
	assign irq_o.gpio = (gpio_s2 != gpio_prev);
	assign irq_o.timer = timer_expire_i;

	// ------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			leds_o <= '0;
			timer_o.en <= 1'b0;
			timer_o.autorestart <= 1'b0;
			timer_o.compare <= '0;
			timer_o.load <= 1'b0;
			soft_reset_o <= 1'b0;
		end else begin
			// strobes last one cycle
			timer_o.load <= 1'b0;
			soft_reset_o <= 1'b0;
			// one-shot mode stops itself
			if (timer_expire_i & ~timer_o.autorestart)
				timer_o.en <= 1'b0;
			if (sel & csr_i.we) begin
				case (reg_idx)
					`REG_GPIO_OUT: leds_o <= csr_i.dw[`GPIO_OUT_W-1:0];
					`REG_TIMER_CTRL: begin
						timer_o.en <= csr_i.dw[0];
						timer_o.autorestart <= csr_i.dw[1];
					end
					`REG_TIMER_COMPARE: timer_o.compare <= csr_i.dw;
					`REG_TIMER_COUNTER: timer_o.load <= 1'b1;
					`REG_RESET: soft_reset_o <= csr_i.dw[0];
					default: ;
				endcase
			end
		end
	end

	// counter preload value, goes with the load strobe
	always_ff @(posedge sys_clk) begin
		if (sel & csr_i.we & (reg_idx == `REG_TIMER_COUNTER))
			timer_o.load_val <= csr_i.dw;
	end

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------
	// registered, zero outside our bank
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel) begin
			case (reg_idx)
				`REG_GPIO_IN: csr_dr_o <= 32'(gpio_s2);
				`REG_GPIO_OUT: csr_dr_o <= 32'(leds_o);
				`REG_TIMER_CTRL: csr_dr_o <= {30'd0, timer_o.autorestart, timer_o.en};
				`REG_TIMER_COMPARE: csr_dr_o <= timer_o.compare;
				`REG_TIMER_COUNTER: csr_dr_o <= timer_count_i;
				`REG_SYSTEM_ID: csr_dr_o <= `SYSTEM_ID;
				default: csr_dr_o <= '0;
			endcase
		end
	end

endmodule

/* design/csr_bridge.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module csr_bridge
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o,
	output csr_req_t csr_o,
	input logic [`SOC_DW-1:0] csr_dr_i
);

	brg_state_e state_q;
	logic [`CSR_AW-1:0] a_q;
	logic [`SOC_DW-1:0] dw_q;
	logic we_q;
	logic ack_q;
	logic [`SOC_DW-1:0] dat_q;

	// ------------------------------------------------------------
	// fsm
	// ------------------------------------------------------------
	// idle -> access (csr cycle) -> ack (wait for read data, then ack)
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state_q <= BRG_IDLE;
			we_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			we_q <= 1'b0;
			case (state_q)
				BRG_IDLE: begin
					if (wb_req_i.cyc & wb_req_i.stb) begin
						we_q <= wb_req_i.we;
						state_q <= BRG_ACCESS;
					end
				end
				BRG_ACCESS: state_q <= BRG_ACK;
				BRG_ACK: begin
					// ack raised once, then back to idle
					if (ack_q) begin
						ack_q <= 1'b0;
						state_q <= BRG_IDLE;
					end else begin
						ack_q <= 1'b1;
					end
				end
				default: state_q <= BRG_IDLE;
			endcase
		end
	end

	// address and write data latched on the strobe
	// a stays put until the next access
	always_ff @(posedge sys_clk) begin
		if (state_q == BRG_IDLE) begin
			a_q <= wb_req_i.adr[`CSR_AW+1:2];
			dw_q <= wb_req_i.dat;
		end
		// slave data registered once more with the ack
		if ((state_q == BRG_ACK) & ~ack_q)
			dat_q <= csr_dr_i;
	end

	assign csr_o.a = a_q;
	assign csr_o.we = we_q;
	assign csr_o.dw = dw_q;

	assign wb_rsp_o.dat = dat_q;
	assign wb_rsp_o.ack = ack_q;

	a_ack_in_ack_state: assert property (
		@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_o.ack |-> (state_q == BRG_ACK)
	) else $error("bridge ack outside BRG_ACK");

endmodule

/* design/wb_bram.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module wb_bram
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	localparam int DEPTH = 2 ** `BRAM_AW;

	logic [`SOC_DW-1:0] mem [DEPTH];
	logic [`BRAM_AW-1:0] idx;
	logic [`SOC_DW-1:0] rd_q;
	logic ack_q;
	logic access;

	// word index, byte offset dropped
	assign idx = wb_req_i.adr[`BRAM_AW+1:2];
	// first sampled cycle of a request only
	assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

	// ------------------------------------------------------------
	// array
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (access & wb_req_i.we) begin
			for (int b = 0; b < `SOC_SELW; b++) begin
				if (wb_req_i.sel[b])
					mem[idx][b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
			end
		end
		// read old word, written data not forwarded
		rd_q <= mem[idx];
	end

	// ack one cycle after stb
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	assign wb_rsp_o.dat = rd_q;
	assign wb_rsp_o.ack = ack_q;

	// master drops stb after ack, so acks never merge
	a_ack_single: assert property (
		@(posedge sys_clk) disable iff (sys_rst_i)
		wb_rsp_o.ack |=> !wb_rsp_o.ack
	) else $error("ram ack lasted two cycles");

endmodule

/* design/wb_decoder.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module wb_decoder
	import soc_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t m_req_i,
	output wb_rsp_t m_rsp_o,
	output wb_req_t ram_req_o,
	output wb_req_t csr_req_o,
	input wb_rsp_t ram_rsp_i,
	input wb_rsp_t csr_rsp_i
);

	region_e region;
	logic dflt_ack_q;

	// ------------------------------------------------------------
	// region decode
	// ------------------------------------------------------------
	// bit 31 ignored, shadow window aliases the normal one
	always_comb begin
		case (m_req_i.adr[30:28])
			`REGION_RAM: region = REG_RAM;
			`REGION_CSR: region = REG_CSR;
			default: region = REG_NONE;
		endcase
	end

	// strobes gated per slave, rest passes through
	always_comb begin
		ram_req_o = m_req_i;
		csr_req_o = m_req_i;
		ram_req_o.cyc = m_req_i.cyc & (region == REG_RAM);
		ram_req_o.stb = m_req_i.stb & (region == REG_RAM);
		csr_req_o.cyc = m_req_i.cyc & (region == REG_CSR);
		csr_req_o.stb = m_req_i.stb & (region == REG_CSR);
	end

	// default responder
	// one-cycle ack for unmapped space
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			dflt_ack_q <= 1'b0;
		else
			dflt_ack_q <= (region == REG_NONE) & m_req_i.cyc & m_req_i.stb & ~dflt_ack_q;
	end

	// ------------------------------------------------------------
	// response mux
	// ------------------------------------------------------------
	always_comb begin
		case (region)
			REG_RAM: m_rsp_o = ram_rsp_i;
			REG_CSR: m_rsp_o = csr_rsp_i;
			default: m_rsp_o = '{dat: '0, ack: dflt_ack_q};
		endcase
	end

endmodule

/* design/reset_gen.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module reset_gen (
	input logic sys_clk,
	input logic trigger_reset_i,
	input logic soft_reset_i,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(`RST_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;
	logic req;

	// external pin or sysctl hard-reset register
	assign req = trigger_reset_i | soft_reset_i;

	// ------------------------------------------------------------
	// hold counter
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (req) begin
			hold_cnt <= CNT_W'(`RST_HOLD_CYCLES);
			sys_rst_o <= 1'b1;
		end else begin
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// drop on the edge where the count reaches zero
			sys_rst_o <= (hold_cnt > CNT_W'(1));
		end
	end

	// reset rises after any request and stays up for the whole hold count
	a_rst_after_req: assert property (
		@(posedge sys_clk) req |=> sys_rst_o [*`RST_HOLD_CYCLES]
	) else $error("reset not held after request");

endmodule

/* design/soc_pkg.sv */
`include "soc_defines.svh"

package soc_pkg;

	// ------------------------------------------------------------
	// wishbone classic
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`SOC_AW-1:0] adr;
		logic [`SOC_DW-1:0] dat;
		logic [`SOC_SELW-1:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	typedef struct packed {
		logic [`SOC_DW-1:0] dat;
		logic ack;
	} wb_rsp_t;

	// csr access, we high for one cycle only
	typedef struct packed {
		logic [`CSR_AW-1:0] a;
		logic we;
		logic [`SOC_DW-1:0] dw;
	} csr_req_t;

	// sysctl to timer
	typedef struct packed {
		logic en;
		logic autorestart;
		logic [31:0] compare;
		logic [31:0] load_val;
		logic load;
	} timer_ctrl_t;

	typedef struct packed {
		logic timer;
		logic gpio;
	} irq_t;

	typedef enum logic [1:0] {
		BRG_IDLE,
		BRG_ACCESS,
		BRG_ACK
	} brg_state_e;

	typedef enum logic [1:0] {
		REG_RAM,
		REG_CSR,
		REG_NONE
	} region_e;

endpackage

/* design/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------
`define SOC_DW 32
`define SOC_AW 32
`define SOC_SELW 4
// csr word address, top 4 bits pick the bank
`define CSR_AW 14
`define CSR_BANK_SYSCTL 4'd1

// ------------------------------------------------------------
// address map, bits 30..28 (bit 31 is the shadow alias)
// ------------------------------------------------------------
`define REGION_RAM 3'b000
`define REGION_CSR 3'b110
`define BRAM_AW 8

// sysctl register word offsets inside the bank
`define REG_GPIO_IN 10'd0
`define REG_GPIO_OUT 10'd1
`define REG_TIMER_CTRL 10'd2
`define REG_TIMER_COMPARE 10'd3
`define REG_TIMER_COUNTER 10'd4
`define REG_SYSTEM_ID 10'd5
`define REG_RESET 10'd6

// misc
`define RST_HOLD_CYCLES 64
`define SYSTEM_ID 32'h13004d31
`define GPIO_IN_W 32
`define GPIO_OUT_W 4

`endif
